// ==== src/lsu_pkg.sv ====
// Load/store unit shared definitions
// Widths, operation and exception encodings, default sizes

package lsu_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int TAG_W  = 4;
  localparam int BE_W   = DATA_W / 8;

  // Default sizes used by the top level
  localparam int DEF_IQ_DEPTH  = 4;
  localparam int DEF_RQ_DEPTH  = 2;
  localparam int DEF_RAM_WORDS = 256;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [BE_W-1:0]   be_t;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [1:0] {
    OP_LW  = 2'd0,
    OP_LBU = 2'd1,
    OP_SW  = 2'd2,
    OP_SB  = 2'd3
  } lsu_op_t;

  // Misaligned has priority over access fault
  typedef enum logic [1:0] {
    EXC_NONE     = 2'd0,
    EXC_MISALIGN = 2'd1,
    EXC_ACCESS   = 2'd2
  } except_t;

endpackage

// ==== src/lsu_cfg_regs.sv ====
// LSU configuration registers
// Access limit, alignment check and busy replay enables

`timescale 1ns/1ps

module lsu_cfg_regs
  import lsu_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,

  input  logic  i_cfg_we,
  input  logic  i_cfg_sel,
  input  data_t i_cfg_wdata,

  output addr_t o_cfg_limit,
  output logic  o_cfg_align_chk,
  output logic  o_cfg_busy_replay_en
);

  // Select 0: limit, select 1: {busy_replay_en, align_chk}
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_cfg_limit          <= '1;
      o_cfg_align_chk      <= 1'b1;
      o_cfg_busy_replay_en <= 1'b1;
    end else if (i_cfg_we) begin
      if (i_cfg_sel == 1'b0) begin
        o_cfg_limit <= i_cfg_wdata[ADDR_W-1:0];
      end else begin
        o_cfg_align_chk      <= i_cfg_wdata[0];
        o_cfg_busy_replay_en <= i_cfg_wdata[1];
      end
    end
  end

endmodule

// ==== src/lsu_issue_queue.sv ====
// LSU issue queue
// Holds dispatched operations and offers them in dispatch order

`timescale 1ns/1ps

module lsu_issue_queue
  import lsu_pkg::*;
#(
  parameter int IQ_DEPTH = 4
)
(
  input  logic    i_clk,
  input  logic    i_rst,

  input  logic    i_disp_valid,
  input  lsu_op_t i_disp_op,
  input  tag_t    i_disp_tag,
  input  addr_t   i_disp_base,
  input  addr_t   i_disp_offset,
  input  data_t   i_disp_wdata,

  input  logic    i_take,
  output logic    o_valid,
  output lsu_op_t o_op,
  output tag_t    o_tag,
  output addr_t   o_base,
  output addr_t   o_offset,
  output data_t   o_wdata,
  output logic    o_full
);

  localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(IQ_DEPTH + 1);

  // Entry payload
  lsu_op_t   q_op     [IQ_DEPTH];
  tag_t      q_tag    [IQ_DEPTH];
  addr_t     q_base   [IQ_DEPTH];
  addr_t     q_offset [IQ_DEPTH];
  data_t     q_wdata  [IQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Strobe while full is dropped
  assign push = i_disp_valid && !o_full;
  assign pop  = i_take && o_valid;

  always_ff @(posedge i_clk) begin
    if (push) begin
      q_op[wr_ptr]     <= i_disp_op;
      q_tag[wr_ptr]    <= i_disp_tag;
      q_base[wr_ptr]   <= i_disp_base;
      q_offset[wr_ptr] <= i_disp_offset;
      q_wdata[wr_ptr]  <= i_disp_wdata;
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  assign o_full   = (count == CNT_W'(IQ_DEPTH));
  assign o_valid  = (count != '0);
  assign o_op     = q_op[rd_ptr];
  assign o_tag    = q_tag[rd_ptr];
  assign o_base   = q_base[rd_ptr];
  assign o_offset = q_offset[rd_ptr];
  assign o_wdata  = q_wdata[rd_ptr];

endmodule

// ==== src/lsu_replay_queue.sv ====
// LSU replay queue
// Keeps operations rejected on memory busy and reissues them in order

`timescale 1ns/1ps

module lsu_replay_queue
  import lsu_pkg::*;
#(
  parameter int RQ_DEPTH = 2
)
(
  input  logic    i_clk,
  input  logic    i_rst,

  input  logic    i_push,
  input  lsu_op_t i_op,
  input  tag_t    i_tag,
  input  addr_t   i_addr,
  input  data_t   i_wdata,

  input  logic    i_mem_busy,
  input  logic    i_take,
  output logic    o_valid,
  output lsu_op_t o_op,
  output tag_t    o_tag,
  output addr_t   o_addr,
  output data_t   o_wdata,
  output logic    o_full
);

  localparam int PTR_W = (RQ_DEPTH > 1) ? $clog2(RQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(RQ_DEPTH + 1);

  lsu_op_t q_op    [RQ_DEPTH];
  tag_t    q_tag   [RQ_DEPTH];
  addr_t   q_addr  [RQ_DEPTH];
  data_t   q_wdata [RQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  assign pop = i_take && o_valid;

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      q_op[wr_ptr]    <= i_op;
      q_tag[wr_ptr]   <= i_tag;
      q_addr[wr_ptr]  <= i_addr;
      q_wdata[wr_ptr] <= i_wdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(RQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(RQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(i_push) - CNT_W'(pop);
    end
  end

  // Full one entry early, the op already in EX1 may still be pushed
  assign o_full  = (count >= CNT_W'(RQ_DEPTH - 1));
  // Held back while memory is busy
  assign o_valid = (count != '0) && !i_mem_busy;
  assign o_op    = q_op[rd_ptr];
  assign o_tag   = q_tag[rd_ptr];
  assign o_addr  = q_addr[rd_ptr];
  assign o_wdata = q_wdata[rd_ptr];

endmodule

// ==== src/lsu_data_ram.sv ====
// LSU data RAM
// Word array, synchronous read, per-byte write enables

`timescale 1ns/1ps

module lsu_data_ram
  import lsu_pkg::*;
#(
  parameter int RAM_WORDS = 256
)
(
  input  logic                         i_clk,
  input  logic                         i_en,
  input  logic [$clog2(RAM_WORDS)-1:0] i_addr,
  input  be_t                          i_be,
  input  data_t                        i_wdata,
  output data_t                        o_rdata
);

  data_t mem [RAM_WORDS];

  // Byte lanes written independently
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      for (int b = 0; b < BE_W; b++) begin
        if (i_be[b]) begin
          mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // Read returns old contents on a same-cycle write
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

// ==== src/lsu_pipe.sv ====
// LSU memory pipe, EX0 select, EX1 check and RAM access, EX2 done
// Busy memory sends the EX1 operation to the replay queue

`timescale 1ns/1ps

module lsu_pipe
  import lsu_pkg::*;
#(
  parameter int RAM_WORDS = 256
)
(
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_mem_busy,

  input  logic    i_iq_valid,
  input  lsu_op_t i_iq_op,
  input  tag_t    i_iq_tag,
  input  addr_t   i_iq_base,
  input  addr_t   i_iq_offset,
  input  data_t   i_iq_wdata,
  output logic    o_iq_take,

  input  logic    i_rq_valid,
  input  lsu_op_t i_rq_op,
  input  tag_t    i_rq_tag,
  input  addr_t   i_rq_addr,
  input  data_t   i_rq_wdata,
  output logic    o_rq_take,
  input  logic    i_rq_full,

  output logic    o_rq_push,
  output lsu_op_t o_rq_op,
  output tag_t    o_rq_tag,
  output addr_t   o_rq_addr,
  output data_t   o_rq_wdata,

  input  addr_t   i_cfg_limit,
  input  logic    i_cfg_align_chk,
  input  logic    i_cfg_busy_replay_en,

  output logic                         o_ram_en,
  output logic [$clog2(RAM_WORDS)-1:0] o_ram_addr,
  output be_t                          o_ram_be,
  output data_t                        o_ram_wdata,
  input  data_t                        i_ram_rdata,

  output logic    o_done_valid,
  output tag_t    o_done_tag,
  output except_t o_done_cause,
  output data_t   o_done_data
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  // ----------------------------------------
  // EX0 select
  // ----------------------------------------
  // Replay wins, fresh issue waits while replay queue is full
  assign o_rq_take = i_rq_valid;
  assign o_iq_take = i_iq_valid && !i_rq_valid && !i_rq_full;

  logic    ex1_valid;
  lsu_op_t ex1_op;
  tag_t    ex1_tag;
  addr_t   ex1_addr;
  data_t   ex1_wdata;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ex1_valid <= 1'b0;
    end else begin
      ex1_valid <= o_rq_take || o_iq_take;
    end
  end

  // Replayed entry carries its computed address
  always_ff @(posedge i_clk) begin
    if (o_rq_take) begin
      ex1_op    <= i_rq_op;
      ex1_tag   <= i_rq_tag;
      ex1_addr  <= i_rq_addr;
      ex1_wdata <= i_rq_wdata;
    end else if (o_iq_take) begin
      ex1_op    <= i_iq_op;
      ex1_tag   <= i_iq_tag;
      ex1_addr  <= i_iq_base + i_iq_offset;
      ex1_wdata <= i_iq_wdata;
    end
  end

  // ----------------------------------------
  // EX1 check and access
  // ----------------------------------------
  except_t ex1_cause;
  logic    ex1_fault;
  logic    ex1_replay;
  logic    ex1_word;
  be_t     ex1_be;

  assign ex1_word = (ex1_op == OP_LW) || (ex1_op == OP_SW);

  always_comb begin
    if (i_cfg_align_chk && ex1_word && (ex1_addr[1:0] != 2'b00)) begin
      ex1_cause = EXC_MISALIGN;
    end else if (ex1_addr >= i_cfg_limit) begin
      ex1_cause = EXC_ACCESS;
    end else begin
      ex1_cause = EXC_NONE;
    end
  end

  assign ex1_fault  = (ex1_cause != EXC_NONE);
  assign ex1_replay = ex1_valid && i_mem_busy && i_cfg_busy_replay_en;

  // Byte lane from the low address bits, loads write nothing
  always_comb begin
    case (ex1_op)
      OP_SW:   ex1_be = '1;
      OP_SB:   ex1_be = be_t'(1) << ex1_addr[1:0];
      default: ex1_be = '0;
    endcase
  end

  assign o_ram_en    = ex1_valid && !ex1_fault && !ex1_replay;
  assign o_ram_addr  = ex1_addr[IDX_W+1:2];
  assign o_ram_be    = o_ram_en ? ex1_be : '0;
  assign o_ram_wdata = (ex1_op == OP_SB) ? {BE_W{ex1_wdata[7:0]}} : ex1_wdata;

  assign o_rq_push  = ex1_replay;
  assign o_rq_op    = ex1_op;
  assign o_rq_tag   = ex1_tag;
  assign o_rq_addr  = ex1_addr;
  assign o_rq_wdata = ex1_wdata;

  // ----------------------------------------
  // EX2 done report
  // ----------------------------------------
  lsu_op_t    ex2_op;
  logic [1:0] ex2_lane;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_done_valid <= 1'b0;
    end else begin
      o_done_valid <= ex1_valid && !ex1_replay;
    end
  end

  always_ff @(posedge i_clk) begin
    o_done_tag   <= ex1_tag;
    o_done_cause <= ex1_cause;
    ex2_op       <= ex1_op;
    ex2_lane     <= ex1_addr[1:0];
  end

  // Zero for stores and faults
  always_comb begin
    o_done_data = '0;
    if (o_done_cause == EXC_NONE) begin
      if (ex2_op == OP_LW) begin
        o_done_data = i_ram_rdata;
      end else if (ex2_op == OP_LBU) begin
        o_done_data = data_t'(i_ram_rdata[8*ex2_lane +: 8]);
      end
    end
  end

endmodule

// ==== src/lsu_top.sv ====
// Load/store unit top level
// Issue and replay queues feeding the memory pipe and data RAM

`timescale 1ns/1ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter int IQ_DEPTH  = DEF_IQ_DEPTH,
  parameter int RQ_DEPTH  = DEF_RQ_DEPTH,
  parameter int RAM_WORDS = DEF_RAM_WORDS
)
(
  input  logic    i_clk,
  input  logic    i_rst,

  input  logic    i_disp_valid,
  input  lsu_op_t i_disp_op,
  input  tag_t    i_disp_tag,
  input  addr_t   i_disp_base,
  input  addr_t   i_disp_offset,
  input  data_t   i_disp_wdata,
  output logic    o_iq_full,

  input  logic    i_cfg_we,
  input  logic    i_cfg_sel,
  input  data_t   i_cfg_wdata,

  input  logic    i_mem_busy,

  output logic    o_done_valid,
  output tag_t    o_done_tag,
  output except_t o_done_cause,
  output data_t   o_done_data
);

  // Configuration
  addr_t cfg_limit;
  logic  cfg_align_chk;
  logic  cfg_busy_replay_en;

  // Issue queue offer
  logic    iq_valid;
  logic    iq_take;
  lsu_op_t iq_op;
  tag_t    iq_tag;
  addr_t   iq_base;
  addr_t   iq_offset;
  data_t   iq_wdata;

  // Replay queue offer and push
  logic    rq_valid;
  logic    rq_take;
  logic    rq_full;
  lsu_op_t rq_op;
  tag_t    rq_tag;
  addr_t   rq_addr;
  data_t   rq_wdata;
  logic    rq_push;
  lsu_op_t rq_push_op;
  tag_t    rq_push_tag;
  addr_t   rq_push_addr;
  data_t   rq_push_wdata;

  // RAM port
  logic                         ram_en;
  logic [$clog2(RAM_WORDS)-1:0] ram_addr;
  be_t                          ram_be;
  data_t                        ram_wdata;
  data_t                        ram_rdata;

  lsu_cfg_regs u_cfg_regs (
    .i_clk                (i_clk),
    .i_rst                (i_rst),
    .i_cfg_we             (i_cfg_we),
    .i_cfg_sel            (i_cfg_sel),
    .i_cfg_wdata          (i_cfg_wdata),
    .o_cfg_limit          (cfg_limit),
    .o_cfg_align_chk      (cfg_align_chk),
    .o_cfg_busy_replay_en (cfg_busy_replay_en)
  );

  lsu_issue_queue #(
    .IQ_DEPTH (IQ_DEPTH)
  ) u_issue_queue (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_disp_valid  (i_disp_valid),
    .i_disp_op     (i_disp_op),
    .i_disp_tag    (i_disp_tag),
    .i_disp_base   (i_disp_base),
    .i_disp_offset (i_disp_offset),
    .i_disp_wdata  (i_disp_wdata),
    .i_take        (iq_take),
    .o_valid       (iq_valid),
    .o_op          (iq_op),
    .o_tag         (iq_tag),
    .o_base        (iq_base),
    .o_offset      (iq_offset),
    .o_wdata       (iq_wdata),
    .o_full        (o_iq_full)
  );

  lsu_replay_queue #(
    .RQ_DEPTH (RQ_DEPTH)
  ) u_replay_queue (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_push     (rq_push),
    .i_op       (rq_push_op),
    .i_tag      (rq_push_tag),
    .i_addr     (rq_push_addr),
    .i_wdata    (rq_push_wdata),
    .i_mem_busy (i_mem_busy),
    .i_take     (rq_take),
    .o_valid    (rq_valid),
    .o_op       (rq_op),
    .o_tag      (rq_tag),
    .o_addr     (rq_addr),
    .o_wdata    (rq_wdata),
    .o_full     (rq_full)
  );

  // ----------------------------------------
  // Memory pipe and RAM
  // ----------------------------------------
  lsu_pipe #(
    .RAM_WORDS (RAM_WORDS)
  ) u_pipe (
    .i_clk                (i_clk),
    .i_rst                (i_rst),
    .i_mem_busy           (i_mem_busy),
    .i_iq_valid           (iq_valid),
    .i_iq_op              (iq_op),
    .i_iq_tag             (iq_tag),
    .i_iq_base            (iq_base),
    .i_iq_offset          (iq_offset),
    .i_iq_wdata           (iq_wdata),
    .o_iq_take            (iq_take),
    .i_rq_valid           (rq_valid),
    .i_rq_op              (rq_op),
    .i_rq_tag             (rq_tag),
    .i_rq_addr            (rq_addr),
    .i_rq_wdata           (rq_wdata),
    .o_rq_take            (rq_take),
    .i_rq_full            (rq_full),
    .o_rq_push            (rq_push),
    .o_rq_op              (rq_push_op),
    .o_rq_tag             (rq_push_tag),
    .o_rq_addr            (rq_push_addr),
    .o_rq_wdata           (rq_push_wdata),
    .i_cfg_limit          (cfg_limit),
    .i_cfg_align_chk      (cfg_align_chk),
    .i_cfg_busy_replay_en (cfg_busy_replay_en),
    .o_ram_en             (ram_en),
    .o_ram_addr           (ram_addr),
    .o_ram_be             (ram_be),
    .o_ram_wdata          (ram_wdata),
    .i_ram_rdata          (ram_rdata),
    .o_done_valid         (o_done_valid),
    .o_done_tag           (o_done_tag),
    .o_done_cause         (o_done_cause),
    .o_done_data          (o_done_data)
  );

  lsu_data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .i_clk   (i_clk),
    .i_en    (ram_en),
    .i_addr  (ram_addr),
    .i_be    (ram_be),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

endmodule

// ==== verification/lsu_checker.sv ====
// Pipe protocol checks, bound into the LSU memory pipe
// Guards RAM writes and queue take rules

`timescale 1ns/1ps

module lsu_checker (
  input logic       i_clk,
  input logic       i_rst,
  input logic       i_ex1_valid,
  input logic       i_ex1_fault,
  input logic       i_ex1_replay,
  input logic [3:0] i_ram_be,
  input logic       i_iq_take,
  input logic       i_rq_take,
  input logic       i_rq_full
);

  // Faulting or replayed op must not touch the RAM
  ram_write_blocked: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_ex1_valid && (i_ex1_fault || i_ex1_replay)) |-> (i_ram_be == 4'b0000))
    else $error("RAM write enabled for a faulting or replayed EX1 operation");

  single_take: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_iq_take && i_rq_take))
    else $error("Both queues taken in the same cycle");

  // Issue queue stalls while the replay queue is full
  no_take_on_rq_full: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rq_full |-> !i_iq_take)
    else $error("Issue queue taken while the replay queue is full");

endmodule

bind lsu_pipe lsu_checker u_checker (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_ex1_valid  (ex1_valid),
  .i_ex1_fault  (ex1_fault),
  .i_ex1_replay (ex1_replay),
  .i_ram_be     (o_ram_be),
  .i_iq_take    (o_iq_take),
  .i_rq_take    (o_rq_take),
  .i_rq_full    (i_rq_full)
);

// ==== verification/lsu_tb.sv ====
// Load/store unit testbench
// Table-driven stimulus, memory model and done scoreboard

`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int IQ_DEPTH  = 4;
  localparam int RQ_DEPTH  = 2;
  localparam int RAM_WORDS = 256;
  localparam int MAX_ROWS  = 40;

  typedef enum {ACT_DISP, ACT_CFG, ACT_BUSY, ACT_BURST} act_t;

  logic    clk;
  logic    rst;
  logic    disp_valid;
  lsu_op_t disp_op;
  tag_t    disp_tag;
  addr_t   disp_base;
  addr_t   disp_offset;
  data_t   disp_wdata;
  logic    iq_full;
  logic    cfg_we;
  logic    cfg_sel;
  data_t   cfg_wdata;
  logic    mem_busy;
  logic    done_valid;
  tag_t    done_tag;
  except_t done_cause;
  data_t   done_data;

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  act_t    t_act   [MAX_ROWS];
  lsu_op_t t_op    [MAX_ROWS];
  tag_t    t_tag   [MAX_ROWS];
  addr_t   t_base  [MAX_ROWS];
  addr_t   t_off   [MAX_ROWS];
  data_t   t_wdata [MAX_ROWS];
  except_t t_cause [MAX_ROWS];
  logic    t_lat   [MAX_ROWS];
  int      n_rows;

  // Memory model and mirrored configuration
  data_t      model_mem [RAM_WORDS];
  logic [3:0] model_wr  [RAM_WORDS];
  addr_t      m_limit;
  logic       m_align;

  // Scoreboard, indexed by tag
  logic    pending   [16];
  except_t exp_cause [16];
  data_t   exp_data  [16];
  int      disp_cyc  [16];
  int      done_cyc  [16];

  int          cyc;
  int          limit;
  int          err_value;
  int          err_other;
  logic [31:0] lfsr_state;

  lsu_top #(
    .IQ_DEPTH  (IQ_DEPTH),
    .RQ_DEPTH  (RQ_DEPTH),
    .RAM_WORDS (RAM_WORDS)
  ) lsu_top_i (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_disp_valid  (disp_valid),
    .i_disp_op     (disp_op),
    .i_disp_tag    (disp_tag),
    .i_disp_base   (disp_base),
    .i_disp_offset (disp_offset),
    .i_disp_wdata  (disp_wdata),
    .o_iq_full     (iq_full),
    .i_cfg_we      (cfg_we),
    .i_cfg_sel     (cfg_sel),
    .i_cfg_wdata   (cfg_wdata),
    .i_mem_busy    (mem_busy),
    .o_done_valid  (done_valid),
    .o_done_tag    (done_tag),
    .o_done_cause  (done_cause),
    .o_done_data   (done_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    logic        fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = (v << 1) | fb;
    end
    return v;
  endfunction

  function automatic except_t model_cause(input lsu_op_t op, input addr_t a);
    logic word;
    word = (op == OP_LW) || (op == OP_SW);
    if (m_align && word && (a[1:0] != 2'b00)) begin
      return EXC_MISALIGN;
    end
    if (a >= m_limit) begin
      return EXC_ACCESS;
    end
    return EXC_NONE;
  endfunction

  // Applies a non-faulting access to the model, returns load data
  task automatic model_access(input lsu_op_t op, input addr_t a, input data_t wd,
                              output data_t rd);
    int idx;
    int lane;
    idx  = (a >> 2) % RAM_WORDS;
    lane = a[1:0];
    rd   = '0;
    case (op)
      OP_SW: begin
        model_mem[idx] = wd;
        model_wr[idx]  = 4'hf;
      end
      OP_SB: begin
        model_mem[idx][8*lane +: 8] = wd[7:0];
        model_wr[idx][lane]         = 1'b1;
      end
      OP_LW: begin
        if (model_wr[idx] != 4'hf) begin
          err_other++;
          $display("Stimulus loads word %0d before writing all of it", idx);
        end
        rd = model_mem[idx];
      end
      default: begin
        if (!model_wr[idx][lane]) begin
          err_other++;
          $display("Stimulus loads a byte of word %0d before writing it", idx);
        end
        rd = data_t'(model_mem[idx][8*lane +: 8]);
      end
    endcase
  endtask

  task automatic add_row(input act_t act, input lsu_op_t op, input tag_t tag,
                         input addr_t base, input addr_t off, input data_t wd,
                         input except_t cause, input logic lat);
    t_act[n_rows]   = act;
    t_op[n_rows]    = op;
    t_tag[n_rows]   = tag;
    t_base[n_rows]  = base;
    t_off[n_rows]   = off;
    t_wdata[n_rows] = wd;
    t_cause[n_rows] = cause;
    t_lat[n_rows]   = lat;
    n_rows++;
  endtask

  // ----------------------------------------
  // Drivers
  // ----------------------------------------
  // With gap set, waits for room and leaves an idle cycle after the strobe
  task automatic send(input lsu_op_t op, input tag_t tag, input addr_t base,
                      input addr_t off, input data_t wd, input except_t cause,
                      input logic gap);
    addr_t   a;
    except_t mc;
    data_t   ed;
    a  = base + off;
    mc = model_cause(op, a);
    ed = '0;
    if (mc != cause) begin
      err_other++;
      $display("Stimulus row for tag %0d expects a cause the address rules do not give", tag);
    end
    if (mc == EXC_NONE) begin
      model_access(op, a, wd, ed);
    end
    if (pending[tag]) begin
      err_other++;
      $display("Tag %0d dispatched again while still outstanding", tag);
    end
    if (gap) begin
      @(negedge clk);
      while (iq_full) @(negedge clk);
    end
    @(posedge clk);
    disp_valid     <= 1'b1;
    disp_op        <= op;
    disp_tag       <= tag;
    disp_base      <= base;
    disp_offset    <= off;
    disp_wdata     <= wd;
    pending[tag]   = 1'b1;
    exp_cause[tag] = mc;
    exp_data[tag]  = ed;
    disp_cyc[tag]  = cyc + 1;
    if (gap) begin
      @(posedge clk);
      disp_valid <= 1'b0;
    end
  endtask

  task automatic wait_tag(input tag_t tag);
    @(negedge clk);
    while (pending[tag]) @(negedge clk);
  endtask

  task automatic wait_idle();
    logic busy_any;
    busy_any = 1'b1;
    while (busy_any) begin
      @(negedge clk);
      busy_any = 1'b0;
      for (int i = 0; i < 16; i++) begin
        busy_any = busy_any | pending[i];
      end
    end
  endtask

  task automatic write_cfg(input logic sel, input data_t wd);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_sel   <= sel;
    cfg_wdata <= wd;
    if (sel == 1'b0) begin
      m_limit = wd[15:0];
    end else begin
      m_align = wd[0];
    end
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  // Loads sent into a random busy window
  task automatic run_busy(input tag_t tag);
    int len;
    int start;
    int stop;
    len = 10 + rand_bits(4);
    @(posedge clk);
    mem_busy <= 1'b1;
    start = cyc;
    for (int i = 0; i < 3; i++) begin
      send(OP_LW, tag_t'(tag + i), 16'h0000, addr_t'(4 * rand_bits(3)), '0, EXC_NONE, 1'b1);
    end
    while (cyc < start + len) @(posedge clk);
    mem_busy <= 1'b0;
    stop = cyc;
    wait_idle();
    // Every load waits for the window to close
    for (int i = 0; i < 3; i++) begin
      assert (done_cyc[tag_t'(tag + i)] > stop) else begin
        err_other++;
        $display("Load tag %0d completed while memory was still busy", tag_t'(tag + i));
      end
    end
  endtask

  // One blocker fills the replay queue, then back to back loads fill the issue queue
  task automatic run_burst(input tag_t tag);
    @(posedge clk);
    mem_busy <= 1'b1;
    send(OP_LW, tag, 16'h0000, addr_t'(4 * rand_bits(3)), '0, EXC_NONE, 1'b1);
    repeat (3) @(posedge clk);
    for (int i = 1; i <= IQ_DEPTH; i++) begin
      send(OP_LW, tag_t'(tag + i), 16'h0000, addr_t'(4 * rand_bits(3)), '0, EXC_NONE, 1'b0);
    end
    @(posedge clk);
    disp_valid <= 1'b0;
    @(negedge clk);
    assert (iq_full == 1'b1) else begin
      err_value++;
      $display("error t=%0t o_iq_full got %0b exp 1", $time, iq_full);
    end
    @(posedge clk);
    mem_busy <= 1'b0;
    wait_idle();
  endtask

  // ----------------------------------------
  // Done scoreboard
  // ----------------------------------------
  always @(negedge clk) begin
    if (!rst && done_valid) begin
      assert (pending[done_tag]) else begin
        err_other++;
        $display("Done reported for tag %0d which is not outstanding", done_tag);
      end
      if (pending[done_tag]) begin
        assert (done_cause == exp_cause[done_tag]) else begin
          err_value++;
          $display("error t=%0t o_done_cause got %0d exp %0d", $time, done_cause,
                   exp_cause[done_tag]);
        end
        assert (done_data == exp_data[done_tag]) else begin
          err_value++;
          $display("error t=%0t o_done_data got %h exp %h", $time, done_data,
                   exp_data[done_tag]);
        end
        pending[done_tag]  = 1'b0;
        done_cyc[done_tag] = cyc;
      end
    end
  end

  // Cycle counter and watchdog
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("Timeout after %0d cycles, the run did not complete", limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    cyc         = 0;
    limit       = 100000;
    err_value   = 0;
    err_other   = 0;
    n_rows      = 0;
    lfsr_state  = 32'h6f25_0323;
    m_limit     = 16'hffff;
    m_align     = 1'b1;
    rst         = 1'b1;
    disp_valid  = 1'b0;
    disp_op     = OP_LW;
    disp_tag    = '0;
    disp_base   = '0;
    disp_offset = '0;
    disp_wdata  = '0;
    cfg_we      = 1'b0;
    cfg_sel     = 1'b0;
    cfg_wdata   = '0;
    mem_busy    = 1'b0;
    for (int i = 0; i < 16; i++) begin
      pending[i] = 1'b0;
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      model_wr[i] = 4'h0;
    end

    // Words 0 to 7 seeded for the random loads
    for (int i = 0; i < 8; i++) begin
      add_row(ACT_DISP, OP_SW, tag_t'(i), 16'h0000, addr_t'(4 * i), 32'h1000_0001 * (i + 3),
              EXC_NONE, 1'b1);
    end
    add_row(ACT_DISP, OP_SW,  4'd1, 16'h0040, 16'h0000, 32'hdead_beef, EXC_NONE, 1'b1);
    add_row(ACT_DISP, OP_LW,  4'd2, 16'h0040, 16'h0000, 32'h0,         EXC_NONE, 1'b1);
    add_row(ACT_DISP, OP_SW,  4'd3, 16'h0050, 16'h0000, 32'h1122_3344, EXC_NONE, 1'b1);
    add_row(ACT_DISP, OP_SB,  4'd4, 16'h0050, 16'h0003, 32'h0000_00a5, EXC_NONE, 1'b1);
    add_row(ACT_DISP, OP_LBU, 4'd5, 16'h0050, 16'h0003, 32'h0,         EXC_NONE, 1'b1);
    add_row(ACT_DISP, OP_LBU, 4'd6, 16'h0051, 16'h0000, 32'h0,         EXC_NONE, 1'b1);
    // Misaligned word, then the check switched off
    add_row(ACT_DISP, OP_LW,  4'd7, 16'h0040, 16'h0002, 32'h0, EXC_MISALIGN, 1'b0);
    add_row(ACT_CFG,  OP_LW,  4'd0, 16'h0001, 16'h0000, 32'h2, EXC_NONE,     1'b0);
    add_row(ACT_DISP, OP_LW,  4'd8, 16'h0040, 16'h0002, 32'h0, EXC_NONE,     1'b0);
    // Lowered limit
    add_row(ACT_DISP, OP_SW,  4'd9,  16'h0080, 16'h0004, 32'hcafe_f00d, EXC_NONE,   1'b0);
    add_row(ACT_CFG,  OP_LW,  4'd0,  16'h0000, 16'h0000, 32'h0080,      EXC_NONE,   1'b0);
    add_row(ACT_DISP, OP_SW,  4'd10, 16'h0080, 16'h0004, 32'h0bad_0bad, EXC_ACCESS, 1'b0);
    add_row(ACT_DISP, OP_LW,  4'd11, 16'h0080, 16'h0000, 32'h0,         EXC_ACCESS, 1'b0);
    add_row(ACT_CFG,  OP_LW,  4'd0,  16'h0000, 16'h0000, 32'hffff,      EXC_NONE,   1'b0);
    add_row(ACT_DISP, OP_LW,  4'd12, 16'h0084, 16'h0000, 32'h0,         EXC_NONE,   1'b0);
    // Busy windows and bursts
    add_row(ACT_BUSY,  OP_LW, 4'd8, '0, '0, '0, EXC_NONE, 1'b0);
    add_row(ACT_BUSY,  OP_LW, 4'd2, '0, '0, '0, EXC_NONE, 1'b0);
    add_row(ACT_BURST, OP_LW, 4'd0, '0, '0, '0, EXC_NONE, 1'b0);
    add_row(ACT_BURST, OP_LW, 4'd9, '0, '0, '0, EXC_NONE, 1'b0);
    limit = n_rows * 40 + 200;

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    for (int r = 0; r < n_rows; r++) begin
      case (t_act[r])
        ACT_DISP: begin
          send(t_op[r], t_tag[r], t_base[r], t_off[r], t_wdata[r], t_cause[r], 1'b1);
          wait_tag(t_tag[r]);
          if (t_lat[r]) begin
            assert (done_cyc[t_tag[r]] - disp_cyc[t_tag[r]] == 3) else begin
              err_value++;
              $display("error t=%0t dispatch to o_done_valid got %0d exp 3", $time,
                       done_cyc[t_tag[r]] - disp_cyc[t_tag[r]]);
            end
          end
        end
        ACT_CFG:  write_cfg(t_base[r][0], t_wdata[r]);
        ACT_BUSY: run_busy(t_tag[r]);
        default:  run_burst(t_tag[r]);
      endcase
    end
    wait_idle();

    $display("Errors: %0d value, %0d other", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/lsu_pkg.sv
src/lsu_cfg_regs.sv
src/lsu_issue_queue.sv
src/lsu_replay_queue.sv
src/lsu_data_ram.sv
src/lsu_pipe.sv
src/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module lsu_tb -Mdir obj_dir -o lsu_tb
	./obj_dir/lsu_tb 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if grep -q "%Error" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)
